//--- logic/int_rs_defines.svh
`ifndef INT_RS_DEFINES_SVH
`define INT_RS_DEFINES_SVH

////////////////////
// issue queue geometry
////////////////////

// number of reservation station slots
`define INTRS_DEPTH 8
// slot index width
`define INTRS_IDX   3

////////////////////
// register and tag widths
////////////////////

`define PHY_REGS    32
`define PHY_IDX     5
`define ROB_IDX     5

// datapath width
`define XLEN        32

`endif

//--- logic/int_rs_pkg.sv
`default_nettype none

`include "int_rs_defines.svh"

package int_rs_pkg;

    // alu operations, shifts are iterative in the alu
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLT = 3'd5,
        SLL = 3'd6,
        SRL = 3'd7
    } alu_op_t;

    ////////////////////
    // instruction word
    ////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // register form when opcode bit 5 is set, immediate form otherwise
    typedef union packed {
        r_type_t rtype;
        i_type_t itype;
    } instr_t;

    ////////////////////
    // pipeline payloads
    ////////////////////

    typedef struct packed {
        instr_t               instr;
        logic [`ROB_IDX-1:0]  rob_id;
        logic [`PHY_IDX-1:0]  rs1_phy;
        logic [`PHY_IDX-1:0]  rs2_phy;
        logic [`PHY_IDX-1:0]  rd_phy;
        logic                 rs1_ready;
        logic                 rs2_ready;
    } dispatch_t;

    // op2_sel high selects the immediate
    typedef struct packed {
        logic [`ROB_IDX-1:0]  rob_id;
        logic [`PHY_IDX-1:0]  rs1_phy;
        logic                 rs1_ready;
        logic [`PHY_IDX-1:0]  rs2_phy;
        logic                 rs2_ready;
        logic [`PHY_IDX-1:0]  rd_phy;
        alu_op_t              fu_opcode;
        logic                 op2_sel;
        logic [`XLEN-1:0]     imm;
    } rs_entry_t;

    typedef struct packed {
        logic [`ROB_IDX-1:0]  rob_id;
        logic [`PHY_IDX-1:0]  rd_phy;
        alu_op_t              fu_opcode;
        logic                 op2_sel;
        logic [`XLEN-1:0]     imm;
        logic [`XLEN-1:0]     rs1_value;
        logic [`XLEN-1:0]     rs2_value;
    } alu_req_t;

    typedef struct packed {
        logic                 valid;
        logic [`ROB_IDX-1:0]  rob_id;
        logic [`PHY_IDX-1:0]  rd_phy;
        logic [`XLEN-1:0]     value;
    } cdb_t;

endpackage

`default_nettype wire

//--- logic/uop_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "int_rs_defines.svh"

module uop_decode (
    input  wire int_rs_pkg::dispatch_t dispatch,
    output int_rs_pkg::rs_entry_t      decoded
);

    logic        is_reg;
    logic [2:0]  funct3;
    logic [11:0] imm12;

    // funct3 sits at the same bits in both forms
    assign is_reg = dispatch.instr.rtype.opcode[5];
    assign funct3 = dispatch.instr.rtype.funct3;
    assign imm12  = dispatch.instr.itype.imm;

    always_comb begin
        decoded.rob_id    = dispatch.rob_id;
        decoded.rs1_phy   = dispatch.rs1_phy;
        decoded.rs1_ready = dispatch.rs1_ready;
        decoded.rs2_phy   = dispatch.rs2_phy;
        decoded.rs2_ready = dispatch.rs2_ready;
        decoded.rd_phy    = dispatch.rd_phy;
        decoded.op2_sel   = ~is_reg;
        decoded.imm       = {{(`XLEN-12){imm12[11]}}, imm12};

        unique case (funct3)
            3'b000: begin
                // sub only exists in register form
                if (is_reg && dispatch.instr.rtype.funct7[5]) begin
                    decoded.fu_opcode = int_rs_pkg::SUB;
                end else begin
                    decoded.fu_opcode = int_rs_pkg::ADD;
                end
            end
            3'b001: decoded.fu_opcode = int_rs_pkg::SLL;
            3'b010: decoded.fu_opcode = int_rs_pkg::SLT;
            // no unsigned compare, sltu folds onto slt
            3'b011: decoded.fu_opcode = int_rs_pkg::SLT;
            3'b100: decoded.fu_opcode = int_rs_pkg::XOR;
            3'b101: decoded.fu_opcode = int_rs_pkg::SRL;
            3'b110: decoded.fu_opcode = int_rs_pkg::OR;
            3'b111: decoded.fu_opcode = int_rs_pkg::AND;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rs_slot.sv
`timescale 1ns/1ns
`default_nettype none

module rs_slot (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  push_en,
    input  wire logic                  clear,
    input  wire int_rs_pkg::rs_entry_t entry_in,
    input  wire int_rs_pkg::cdb_t      cdb,
    output logic                       valid,
    output logic                       request,
    output int_rs_pkg::rs_entry_t      entry
);

    // set ready flags whose tag matches the broadcast
    function automatic int_rs_pkg::rs_entry_t wake(
        input int_rs_pkg::rs_entry_t e,
        input int_rs_pkg::cdb_t      c
    );
        int_rs_pkg::rs_entry_t w;
        w = e;
        if (c.valid && c.rd_phy == e.rs1_phy) begin
            w.rs1_ready = 1'b1;
        end
        if (c.valid && c.rd_phy == e.rs2_phy) begin
            w.rs2_ready = 1'b1;
        end
        return w;
    endfunction

    int_rs_pkg::rs_entry_t entry_next;

    assign entry_next = push_en ? entry_in : entry;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (push_en) begin
            valid <= 1'b1;
        end else if (clear) begin
            valid <= 1'b0;
        end
    end

    // incoming entry sees the same-edge broadcast too
    always_ff @(posedge clk) begin
        entry <= wake(entry_next, cdb);
    end

    assign request = valid & entry.rs1_ready & (entry.rs2_ready | entry.op2_sel);

endmodule

`default_nettype wire

//--- logic/int_rs_ordered.sv
`timescale 1ns/1ns
`default_nettype none

`include "int_rs_defines.svh"

module int_rs_ordered (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  push_valid,
    input  wire int_rs_pkg::rs_entry_t push_entry,
    input  wire int_rs_pkg::cdb_t      cdb,
    input  wire logic                  alu_ready,
    input  wire logic [`XLEN-1:0]      rs1_value,
    input  wire logic [`XLEN-1:0]      rs2_value,
    output logic                       push_ready,
    output logic                       issue_valid,
    output logic [`PHY_IDX-1:0]        rs1_phy,
    output logic [`PHY_IDX-1:0]        rs2_phy,
    output int_rs_pkg::alu_req_t       issue
);

    localparam int DEPTH = `INTRS_DEPTH;
    localparam int IDX_W = `INTRS_IDX;

    logic [DEPTH-1:0]      slot_valid;
    logic [DEPTH-1:0]      slot_request;
    int_rs_pkg::rs_entry_t slot_entry [DEPTH];

    // top counts occupied slots, so it needs one bit more than an index
    logic [IDX_W:0]        top;
    logic [IDX_W:0]        top_after_pop;
    logic [IDX_W:0]        free_count;
    logic [IDX_W-1:0]      grant_idx;
    logic                  pop;
    logic                  push;
    int_rs_pkg::rs_entry_t oldest;

    assign pop           = issue_valid & alu_ready;
    assign push          = push_valid & push_ready;
    assign top_after_pop = top - {{IDX_W{1'b0}}, pop};

    ////////////////////
    // slot array
    ////////////////////

    for (genvar i = 0; i < DEPTH; i++) begin : slots
        logic                  next_valid;
        int_rs_pkg::rs_entry_t next_entry;
        logic                  compress;
        logic                  push_here;
        logic                  push_en;
        logic                  clear;
        int_rs_pkg::rs_entry_t entry_in;

        if (i < DEPTH - 1) begin : has_next
            assign next_valid = slot_valid[i+1];
            assign next_entry = slot_entry[i+1];
        end else begin : no_next
            assign next_valid = 1'b0;
            assign next_entry = '0;
        end

        // slots at and behind the issued one move forward
        assign compress  = pop && (IDX_W'(i) >= grant_idx);
        assign push_here = push && (top_after_pop == (IDX_W+1)'(i));

        always_comb begin
            push_en  = 1'b0;
            clear    = 1'b0;
            entry_in = next_entry;
            if (push_here) begin
                push_en  = 1'b1;
                entry_in = push_entry;
            end else if (compress) begin
                push_en = next_valid;
                clear   = ~next_valid;
            end
        end

        rs_slot slot (
            .clk      (clk),
            .rst      (rst),
            .push_en  (push_en),
            .clear    (clear),
            .entry_in (entry_in),
            .cdb      (cdb),
            .valid    (slot_valid[i]),
            .request  (slot_request[i]),
            .entry    (slot_entry[i])
        );
    end

    ////////////////////
    // push and pop
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            top <= '0;
        end else begin
            top <= top_after_pop + {{IDX_W{1'b0}}, push};
        end
    end

    always_comb begin
        free_count = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!slot_valid[i]) begin
                free_count = free_count + 1'b1;
            end
        end
    end

    assign push_ready = (free_count != '0);

    ////////////////////
    // oldest-first issue
    ////////////////////

    // lowest index is oldest
    always_comb begin
        issue_valid = 1'b0;
        grant_idx   = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (slot_request[i]) begin
                issue_valid = 1'b1;
                grant_idx   = IDX_W'(i);
            end
        end
    end

    assign oldest  = slot_entry[grant_idx];
    assign rs1_phy = oldest.rs1_phy;
    assign rs2_phy = oldest.rs2_phy;

    always_comb begin
        issue.rob_id    = oldest.rob_id;
        issue.rd_phy    = oldest.rd_phy;
        issue.fu_opcode = oldest.fu_opcode;
        issue.op2_sel   = oldest.op2_sel;
        issue.imm       = oldest.imm;
        issue.rs1_value = rs1_value;
        issue.rs2_value = rs2_value;
    end

endmodule

`default_nettype wire

//--- logic/fu_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "int_rs_defines.svh"

module fu_alu (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 issue_valid,
    input  wire int_rs_pkg::alu_req_t issue,
    output logic                      alu_ready,
    output int_rs_pkg::cdb_t          alu_result
);

    localparam int SH_W = $clog2(`XLEN);

    logic [`XLEN-1:0]    op2;
    logic [SH_W-1:0]     shamt;
    logic                accept;
    logic                is_shift;
    logic [`XLEN-1:0]    quick_value;

    logic                busy;
    logic                shift_left;
    logic [SH_W-1:0]     shift_cnt;
    logic [`XLEN-1:0]    shift_val;
    logic [`XLEN-1:0]    shift_step;

    logic                result_valid;
    logic [`ROB_IDX-1:0] result_rob;
    logic [`PHY_IDX-1:0] result_rd;
    logic [`XLEN-1:0]    result_value;

    assign op2       = issue.op2_sel ? issue.imm : issue.rs2_value;
    assign shamt     = op2[SH_W-1:0];
    assign alu_ready = ~busy;
    assign accept    = issue_valid & alu_ready;
    assign is_shift  = (issue.fu_opcode == int_rs_pkg::SLL) ||
                       (issue.fu_opcode == int_rs_pkg::SRL);

    // single-cycle result; a shift only lands here when the amount is zero
    always_comb begin
        unique case (issue.fu_opcode)
            int_rs_pkg::ADD: quick_value = issue.rs1_value + op2;
            int_rs_pkg::SUB: quick_value = issue.rs1_value - op2;
            int_rs_pkg::AND: quick_value = issue.rs1_value & op2;
            int_rs_pkg::OR:  quick_value = issue.rs1_value | op2;
            int_rs_pkg::XOR: quick_value = issue.rs1_value ^ op2;
            int_rs_pkg::SLT: begin
                quick_value = {{(`XLEN-1){1'b0}}, $signed(issue.rs1_value) < $signed(op2)};
            end
            int_rs_pkg::SLL: quick_value = issue.rs1_value;
            int_rs_pkg::SRL: quick_value = issue.rs1_value;
        endcase
    end

    assign shift_step = shift_left ? (shift_val << 1) : (shift_val >> 1);

    ////////////////////
    // control
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (busy) begin
                // last bit shifted this edge
                if (shift_cnt == SH_W'(1)) begin
                    busy         <= 1'b0;
                    result_valid <= 1'b1;
                end
            end else if (accept) begin
                if (is_shift && shamt != '0) begin
                    busy <= 1'b1;
                end else begin
                    result_valid <= 1'b1;
                end
            end
        end
    end

    // datapath, one bit per cycle while busy
    always_ff @(posedge clk) begin
        if (busy) begin
            shift_val    <= shift_step;
            shift_cnt    <= shift_cnt - SH_W'(1);
            result_value <= shift_step;
        end else if (accept) begin
            result_rob   <= issue.rob_id;
            result_rd    <= issue.rd_phy;
            result_value <= quick_value;
            shift_val    <= issue.rs1_value;
            shift_cnt    <= shamt;
            shift_left   <= (issue.fu_opcode == int_rs_pkg::SLL);
        end
    end

    always_comb begin
        alu_result.valid  = result_valid;
        alu_result.rob_id = result_rob;
        alu_result.rd_phy = result_rd;
        alu_result.value  = result_value;
    end

endmodule

`default_nettype wire

//--- logic/phys_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "int_rs_defines.svh"

module phys_regfile (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire int_rs_pkg::cdb_t    alu_result,
    input  wire logic [`PHY_IDX-1:0] rs1_phy,
    input  wire logic [`PHY_IDX-1:0] rs2_phy,
    output logic [`XLEN-1:0]         rs1_value,
    output logic [`XLEN-1:0]         rs2_value,
    output int_rs_pkg::cdb_t         cdb
);

    logic [`XLEN-1:0] regs [`PHY_REGS];

    ////////////////////
    // result write
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `PHY_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (alu_result.valid) begin
            regs[alu_result.rd_phy] <= alu_result.value;
        end
    end

    // reads see a write landing this cycle
    always_comb begin
        rs1_value = regs[rs1_phy];
        if (alu_result.valid && alu_result.rd_phy == rs1_phy) begin
            rs1_value = alu_result.value;
        end
        rs2_value = regs[rs2_phy];
        if (alu_result.valid && alu_result.rd_phy == rs2_phy) begin
            rs2_value = alu_result.value;
        end
    end

    // broadcast goes out in the same cycle as the write
    assign cdb = alu_result;

endmodule

`default_nettype wire

//--- logic/int_issue_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "int_rs_defines.svh"

module int_issue_top (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  dispatch_valid,
    input  wire int_rs_pkg::dispatch_t dispatch,
    output logic                       dispatch_ready,
    output int_rs_pkg::cdb_t           complete
);

    int_rs_pkg::rs_entry_t decoded;
    int_rs_pkg::alu_req_t  issue;
    int_rs_pkg::cdb_t      alu_result;
    logic                  issue_valid;
    logic                  alu_ready;
    logic [`PHY_IDX-1:0]   rs1_phy;
    logic [`PHY_IDX-1:0]   rs2_phy;
    logic [`XLEN-1:0]      rs1_value;
    logic [`XLEN-1:0]      rs2_value;

    uop_decode decode0 (
        .dispatch (dispatch),
        .decoded  (decoded)
    );

    int_rs_ordered rs0 (
        .clk         (clk),
        .rst         (rst),
        .push_valid  (dispatch_valid),
        .push_entry  (decoded),
        .cdb         (complete),
        .alu_ready   (alu_ready),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .push_ready  (dispatch_ready),
        .issue_valid (issue_valid),
        .rs1_phy     (rs1_phy),
        .rs2_phy     (rs2_phy),
        .issue       (issue)
    );

    fu_alu alu0 (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .alu_ready   (alu_ready),
        .alu_result  (alu_result)
    );

    // result stage, its broadcast wakes the queue and reports completion
    phys_regfile prf0 (
        .clk        (clk),
        .rst        (rst),
        .alu_result (alu_result),
        .rs1_phy    (rs1_phy),
        .rs2_phy    (rs2_phy),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .cdb        (complete)
    );

endmodule

`default_nettype wire

//--- verif/int_issue_assert.sv
`timescale 1ns/1ns
`default_nettype none

module int_issue_assert (
    input wire logic             clk,
    input wire logic             rst,
    input wire logic             dispatch_valid,
    input wire logic             dispatch_ready,
    input wire int_rs_pkg::cdb_t complete
);

    // raised by any failing property, watched from the testbench
    logic violation = 1'b0;

    ////////////////////
    // reset
    ////////////////////

    // once reset has been sampled twice the result stage is quiet
    quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !complete.valid)
        else begin
            violation = 1'b1;
            $error("completion pulse while reset is held");
        end

    ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> dispatch_ready)
        else begin
            violation = 1'b1;
            $error("dispatch_ready low in the first cycle after reset");
        end

    ////////////////////
    // dispatch protocol
    ////////////////////

    no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) dispatch_valid |-> dispatch_ready)
        else begin
            violation = 1'b1;
            $error("dispatch_valid high while dispatch_ready is low");
        end

endmodule

bind int_issue_top int_issue_assert asrt0 (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .complete       (complete)
);

`default_nettype wire

//--- verif/int_issue_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "int_rs_defines.svh"

module int_issue_tb;

    localparam int GROUP_LEN       = 4;
    localparam int NUM_RANDOM      = 120;
    localparam int NUM_UOPS        = NUM_RANDOM + GROUP_LEN + 1;
    localparam int WATCHDOG_CYCLES = NUM_UOPS * 200;
    localparam int PW              = `PHY_IDX;
    localparam int ROB_N           = 1 << `ROB_IDX;

    logic                  clk;
    logic                  rst;
    logic                  dispatch_valid;
    int_rs_pkg::dispatch_t dispatch;
    logic                  dispatch_ready;
    int_rs_pkg::cdb_t      complete;

    int_issue_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .complete       (complete)
    );

    ////////////////////
    // shadow model
    ////////////////////

    logic [`XLEN-1:0]     shadow [`PHY_REGS];
    logic [`PHY_REGS-1:0] pend_dest;
    int                   readers [`PHY_REGS];
    logic [`XLEN-1:0]     exp_value [ROB_N];
    logic [PW-1:0]        exp_rd [ROB_N];
    logic [PW-1:0]        src1 [ROB_N];
    logic [PW-1:0]        src2 [ROB_N];
    logic                 uses_rs2 [ROB_N];
    logic                 in_flight [ROB_N];
    int                   group_pos [ROB_N];
    int                   next_group;
    int                   outstanding;
    int                   seq;
    logic [PW-1:0]        last_rd;
    logic                 ready_seen;
    logic                 drove_last;
    logic                 saw_full;
    logic [31:0]          lfsr_state;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [`XLEN-1:0] ref_result(input int_rs_pkg::alu_op_t op,
                                                    input logic [`XLEN-1:0] a,
                                                    input logic [`XLEN-1:0] b);
        logic [`XLEN-1:0] r;
        r = '0;
        case (op)
            int_rs_pkg::ADD: r = a + b;
            int_rs_pkg::SUB: r = a - b;
            int_rs_pkg::AND: r = a & b;
            int_rs_pkg::OR:  r = a | b;
            int_rs_pkg::XOR: r = a ^ b;
            int_rs_pkg::SLT: r = ($signed(a) < $signed(b)) ? 1 : 0;
            int_rs_pkg::SLL: r = a << b[4:0];
            int_rs_pkg::SRL: r = a >> b[4:0];
        endcase
        return r;
    endfunction

    // rv32 style encoding, register form has opcode bit 5 set
    function automatic logic [31:0] encode(input int_rs_pkg::alu_op_t op, input logic reg_form,
                                           input logic [PW-1:0] rs1, input logic [PW-1:0] rs2,
                                           input logic [PW-1:0] rd, input logic [11:0] imm12);
        logic [2:0] f3;
        logic [6:0] f7;
        case (op)
            int_rs_pkg::SLL: f3 = 3'b001;
            int_rs_pkg::SLT: f3 = 3'b010;
            int_rs_pkg::XOR: f3 = 3'b100;
            int_rs_pkg::SRL: f3 = 3'b101;
            int_rs_pkg::OR:  f3 = 3'b110;
            int_rs_pkg::AND: f3 = 3'b111;
            default:         f3 = 3'b000;
        endcase
        f7 = (op == int_rs_pkg::SUB) ? 7'b0100000 : 7'b0000000;
        if (reg_form) begin
            return {f7, rs2, rs1, f3, rd, 7'b0110011};
        end else begin
            return {imm12, rs1, f3, rd, 7'b0010011};
        end
    endfunction

    function automatic logic [PW-1:0] ready_src();
        logic [PW-1:0] r;
        r = PW'(take_bits(PW));
        while (pend_dest[r]) begin
            r = r + PW'(1);
        end
        return r;
    endfunction

    // no pending writer and no in-flight reader
    function automatic logic [PW-1:0] free_dest();
        logic [PW-1:0] r;
        r = PW'(take_bits(PW));
        while (pend_dest[r] || readers[r] != 0) begin
            r = r + PW'(1);
        end
        return r;
    endfunction

    ////////////////////
    // dispatch driver
    ////////////////////

    task automatic send_uop(input int_rs_pkg::alu_op_t op, input logic reg_form,
                            input logic [11:0] imm12, input logic force_ready, input int gpos);
        int_rs_pkg::dispatch_t d;
        logic [PW-1:0]         rs1;
        logic [PW-1:0]         rs2;
        logic [PW-1:0]         rd;
        logic [`XLEN-1:0]      b;
        logic [`ROB_IDX-1:0]   rob;
        // a slot is certain if the count bound holds or nothing was pushed into a ready queue
        while (!(outstanding < `INTRS_DEPTH || (ready_seen && !drove_last))) begin
            dispatch_valid <= 1'b0;
            drove_last = 1'b0;
            @(posedge clk);
        end
        if (force_ready) begin
            rs1 = ready_src();
            rs2 = ready_src();
        end else begin
            rs1 = take_bits(1) != 0 ? last_rd : PW'(take_bits(PW));
            rs2 = PW'(take_bits(PW));
        end
        if (!reg_form) begin
            rs2 = rs1;
        end
        readers[rs1]++;
        if (reg_form) begin
            readers[rs2]++;
        end
        rd  = free_dest();
        rob = seq[`ROB_IDX-1:0];
        b   = reg_form ? shadow[rs2] : {{(`XLEN-12){imm12[11]}}, imm12};
        exp_value[rob] = ref_result(op, shadow[rs1], b);
        exp_rd[rob]    = rd;
        src1[rob]      = rs1;
        src2[rob]      = rs2;
        uses_rs2[rob]  = reg_form;
        in_flight[rob] = 1'b1;
        group_pos[rob] = gpos;
        d.instr     = encode(op, reg_form, rs1, rs2, rd, imm12);
        d.rob_id    = rob;
        d.rs1_phy   = rs1;
        d.rs2_phy   = rs2;
        d.rd_phy    = rd;
        d.rs1_ready = !pend_dest[rs1];
        d.rs2_ready = !pend_dest[rs2];
        pend_dest[rd] = 1'b1;
        shadow[rd]    = exp_value[rob];
        last_rd       = rd;
        outstanding++;
        seq++;
        dispatch_valid <= 1'b1;
        dispatch       <= d;
        drove_last = 1'b1;
        @(posedge clk);
    endtask

    ////////////////////
    // completion checks
    ////////////////////

    task automatic check_completion();
        logic [`ROB_IDX-1:0] rob;
        rob = complete.rob_id;
        assert (in_flight[rob]) else begin
            $display("completion for rob_id %0d, which is not in flight", rob);
            $display("Test failed");
            $fatal(1);
        end
        assert (complete.value == exp_value[rob] && complete.rd_phy == exp_rd[rob]) else begin
            $display("Mismatch at %0t: rob_id %0d wrote p%0d = %h, expected p%0d = %h",
                     $time, rob, complete.rd_phy, complete.value, exp_rd[rob], exp_value[rob]);
            $display("Test failed");
            $fatal(1);
        end
        if (group_pos[rob] >= 0) begin
            assert (group_pos[rob] == next_group) else begin
                $display("age order broken, group entry %0d completed while %0d was due",
                         group_pos[rob], next_group);
                $display("Test failed");
                $fatal(1);
            end
            next_group++;
        end
        in_flight[rob] = 1'b0;
        pend_dest[exp_rd[rob]] = 1'b0;
        readers[src1[rob]]--;
        if (uses_rs2[rob]) begin
            readers[src2[rob]]--;
        end
        outstanding--;
    endtask

    always @(negedge clk) begin
        if (dut0.asrt0.violation) begin
            $display("a protocol assertion on the DUT failed");
            $display("Test failed");
            $fatal(1);
        end
        if (!rst) begin
            ready_seen = dispatch_ready;
            if (!dispatch_ready) begin
                saw_full = 1'b1;
                // queued entries are always a subset of the uncompleted ones
                assert (outstanding >= `INTRS_DEPTH) else begin
                    $display("Mismatch at %0t: dispatch_ready low with %0d uops outstanding",
                             $time, outstanding);
                    $display("Test failed");
                    $fatal(1);
                end
            end
            if (complete.valid) begin
                check_completion();
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired, completions stopped arriving");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        logic [2:0]           opbits;
        int_rs_pkg::alu_op_t  op;
        logic                 form;
        logic [11:0]          imm;
        lfsr_state     = 32'h743e5746;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        pend_dest      = '0;
        next_group     = 0;
        outstanding    = 0;
        seq            = 0;
        last_rd        = '0;
        ready_seen     = 1'b0;
        drove_last     = 1'b0;
        saw_full       = 1'b0;
        for (int r = 0; r < `PHY_REGS; r++) begin
            shadow[r]  = '0;
            readers[r] = 0;
        end
        for (int t = 0; t < ROB_N; t++) begin
            in_flight[t] = 1'b0;
            group_pos[t] = -1;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // long shift, then ready adds back to back behind it
        send_uop(int_rs_pkg::SLL, 1'b0, 12'd31, 1'b1, -1);
        for (int g = 0; g < GROUP_LEN; g++) begin
            send_uop(int_rs_pkg::ADD, 1'b0, 12'(take_bits(12)), 1'b1, g);
        end

        // random mix with chains through the last destination
        for (int n = 0; n < NUM_RANDOM; n++) begin
            opbits = 3'(take_bits(3));
            op     = int_rs_pkg::alu_op_t'(opbits);
            form   = take_bits(1) != 0;
            if (op == int_rs_pkg::SUB) begin
                form = 1'b1;
            end
            if (op == int_rs_pkg::SLL || op == int_rs_pkg::SRL) begin
                imm = 12'(take_bits(5));
            end else begin
                imm = 12'(take_bits(12));
            end
            send_uop(op, form, imm, 1'b0, -1);
        end
        dispatch_valid <= 1'b0;

        while (outstanding != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        if (!saw_full || dut0.asrt0.violation) begin
            $display("queue never filled or protocol assertion failed");
            $display("Test failed");
            $fatal(1);
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+logic
logic/int_rs_pkg.sv
logic/uop_decode.sv
logic/rs_slot.sv
logic/int_rs_ordered.sv
logic/fu_alu.sv
logic/phys_regfile.sv
logic/int_issue_top.sv
verif/int_issue_assert.sv
verif/int_issue_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it; exit status is the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module int_issue_tb \
    -Mdir obj_dir \
    -f verilog.f

./obj_dir/Vint_issue_tb +verilator+error+limit+10
